// File: patch_pkg.sv
package patch_pkg;

    // Patch and cluster sizes
    localparam int NUM_THREAD = 32;
    localparam int NUM_RT     = 4;
    localparam int NUM_IC     = 4;

    // Thread id width for a power-of-two NUM_THREAD
    localparam int THREAD_W   = 5;

    localparam int WORD_W     = 32;

    // Thread id inside one patch
    typedef logic [THREAD_W-1:0] thread_id_t;

    // Pixel id, pc and sp
    typedef logic [WORD_W-1:0] word_t;

    // One bit per core
    typedef logic [NUM_RT-1:0] rt_mask_t;
    typedef logic [NUM_IC-1:0] ic_mask_t;

    // Finished tasks with a spare bit so NUM_THREAD fits
    typedef logic [THREAD_W:0] done_count_t;

    // Load sequencer
    typedef enum logic {
        IDLE,
        LOADING
    } load_state_t;

endpackage

// File: thread_q_if.sv
`timescale 1ns/1ps

interface thread_q_if import patch_pkg::*; ();

    logic       push;
    thread_id_t push_id;
    logic       pop;
    logic       empty;
    thread_id_t head;

    modport producer (
        output push,
        output push_id
    );

    modport consumer (
        output pop,
        input  empty,
        input  head
    );

    modport fifo (
        input  push,
        input  push_id,
        input  pop,
        output empty,
        output head
    );

endinterface

// File: thread_fifo.sv
`timescale 1ns/1ps

module thread_fifo import patch_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    thread_q_if.fifo        q
);

    thread_id_t            mem [NUM_THREAD];
    logic [THREAD_W-1:0]   rd_ptr;
    logic [THREAD_W-1:0]   wr_ptr;
    logic [THREAD_W:0]     count;

    // Pointers wrap on their own at NUM_THREAD entries
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (q.push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (q.pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({q.push, q.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (q.push) begin
            mem[wr_ptr] <= q.push_id;
        end
    end

    // Show-ahead read
    assign q.head  = mem[rd_ptr];
    assign q.empty = (count == '0);

endmodule

// File: switch_collector.sv
`timescale 1ns/1ps

module switch_collector import patch_pkg::*; #(
    parameter int NUM_CORES = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [NUM_CORES-1:0]          switch_req,
    input  thread_id_t                    req_id [NUM_CORES],
    input  logic                          block,
    output logic [NUM_CORES-1:0]          grant,
    output logic [$clog2(NUM_CORES)-1:0]  grant_idx,
    thread_q_if.producer                  q
);

    logic [NUM_CORES-1:0] pending;
    logic [NUM_CORES-1:0] active;
    logic                 found;

    // New pulses and held requests compete together
    assign active = switch_req | pending;

    // Lowest index wins
    always_comb begin
        found     = 1'b0;
        grant_idx = '0;
        for (int i = 0; i < NUM_CORES; i++) begin
            if (active[i] && !found) begin
                found     = 1'b1;
                grant_idx = ($clog2(NUM_CORES))'(i);
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found && !block) begin
            grant[grant_idx] = 1'b1;
        end
    end

    // Losers keep their request until granted
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            pending <= active & ~grant;
        end
    end

    assign q.push    = |grant;
    assign q.push_id = req_id[grant_idx];

endmodule

// File: core_allocator.sv
`timescale 1ns/1ps

module core_allocator import patch_pkg::*; #(
    parameter int NUM_CORES = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [NUM_CORES-1:0]  core_release,
    output logic [NUM_CORES-1:0]  dispatch,
    thread_q_if.consumer          q
);

    logic [NUM_CORES-1:0] busy;
    logic                 picked;

    // Lowest free core takes the queue head
    always_comb begin
        dispatch = '0;
        picked   = 1'b0;
        if (!q.empty) begin
            for (int i = 0; i < NUM_CORES; i++) begin
                if (!busy[i] && !picked) begin
                    dispatch[i] = 1'b1;
                    picked      = 1'b1;
                end
            end
        end
    end

    assign q.pop = picked;

    // A core is only released while busy, so set and clear never overlap
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            busy <= (busy & ~core_release) | dispatch;
        end
    end

endmodule

// File: pixel_loader.sv
`timescale 1ns/1ps

module pixel_loader import patch_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load_cp,
    input  word_t       pixel_id_cp,
    input  thread_id_t  rd_id,
    output word_t       rd_pixel,
    output logic        loading,
    output logic        load_push,
    output thread_id_t  load_id
);

    load_state_t state;
    load_state_t state_nxt;
    thread_id_t  addr;
    word_t       pixel_tbl [NUM_THREAD];

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Cycle 0 is the IDLE cycle that sees load_cp
    always_comb begin
        state_nxt = state;
        load_push = 1'b0;
        case (state)
            IDLE: begin
                if (load_cp) begin
                    load_push = 1'b1;
                    state_nxt = LOADING;
                end
            end
            LOADING: begin
                load_push = 1'b1;
                if (addr == thread_id_t'(NUM_THREAD - 1)) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // Wraps back to 0 after the last entry
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (load_push) begin
            addr <= addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_push) begin
            pixel_tbl[addr] <= pixel_id_cp;
        end
    end

    assign load_id  = addr;
    assign loading  = load_push;
    assign rd_pixel = pixel_tbl[rd_id];

endmodule

// File: context_store.sv
`timescale 1ns/1ps

module context_store import patch_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        save,
    input  thread_id_t  save_id,
    input  word_t       save_pc,
    input  word_t       save_sp,
    input  logic        clear,
    input  thread_id_t  clear_id,
    input  thread_id_t  rd_id,
    output word_t       rd_pc,
    output word_t       rd_sp
);

    word_t pc_tbl [NUM_THREAD];
    word_t sp_tbl [NUM_THREAD];

    // Fresh threads start at pc 0 and sp 0
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_THREAD; i++) begin
                pc_tbl[i] <= '0;
                sp_tbl[i] <= '0;
            end
        end else begin
            if (save) begin
                pc_tbl[save_id] <= save_pc;
                sp_tbl[save_id] <= save_sp;
            end
            if (clear) begin
                pc_tbl[clear_id] <= '0;
                sp_tbl[clear_id] <= '0;
            end
        end
    end

    assign rd_pc = pc_tbl[rd_id];
    assign rd_sp = sp_tbl[rd_id];

endmodule

// File: patch_dispatcher.sv
`timescale 1ns/1ps

module patch_dispatcher import patch_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        load_cp,
    input  word_t       pixel_id_cp,

    input  rt_mask_t    task_done_rt,
    input  rt_mask_t    context_switch_rt,
    input  thread_id_t  thread_id_in_rt [NUM_RT],
    input  word_t       pc_in_rt [NUM_RT],
    input  word_t       stack_ptr_in_rt [NUM_RT],

    input  ic_mask_t    context_switch_ic,
    input  thread_id_t  thread_id_in_ic [NUM_IC],

    output logic        patch_done,

    output rt_mask_t    job_dispatch_rt,
    output thread_id_t  thread_id_out_rt,
    output word_t       pixel_id_rt,
    output word_t       pc_out_rt,
    output word_t       sp_out_rt,

    output ic_mask_t    job_dispatch_ic,
    output thread_id_t  thread_id_out_ic,

    output logic        q_en_rt2ic,
    output rt_mask_t    core_id_rt2ic,
    output logic        q_en_ic2rt,
    output ic_mask_t    core_id_ic2rt
);

    rt_mask_t                  rt_grant;
    logic [$clog2(NUM_RT)-1:0] rt_grant_idx;
    ic_mask_t                  ic_grant;
    logic                      loading;
    logic                      load_push;
    thread_id_t                load_id;
    done_count_t               done_cnt;

    thread_q_if q_to_rt ();
    thread_q_if q_to_ic ();
    // IC switch-outs before they merge with the loader pushes
    thread_q_if ic_sw_q ();

    pixel_loader pixel_loader_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_cp     (load_cp),
        .pixel_id_cp (pixel_id_cp),
        .rd_id       (q_to_rt.head),
        .rd_pixel    (pixel_id_rt),
        .loading     (loading),
        .load_push   (load_push),
        .load_id     (load_id)
    );

    // RT to IC
    switch_collector #(.NUM_CORES(NUM_RT)) rt_collector_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .switch_req (context_switch_rt),
        .req_id     (thread_id_in_rt),
        .block      (1'b0),
        .grant      (rt_grant),
        .grant_idx  (rt_grant_idx),
        .q          (q_to_ic.producer)
    );

    thread_fifo q_to_ic_fifo_i (.clk(clk), .rst_n(rst_n), .q(q_to_ic.fifo));

    core_allocator #(.NUM_CORES(NUM_IC)) ic_alloc_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_release (ic_grant),
        .dispatch     (job_dispatch_ic),
        .q            (q_to_ic.consumer)
    );

    // IC to RT is held off while the loader owns the queue
    switch_collector #(.NUM_CORES(NUM_IC)) ic_collector_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .switch_req (context_switch_ic),
        .req_id     (thread_id_in_ic),
        .block      (loading),
        .grant      (ic_grant),
        .grant_idx  (),
        .q          (ic_sw_q.producer)
    );

    assign q_to_rt.push    = ic_sw_q.push | load_push;
    assign q_to_rt.push_id = load_push ? load_id : ic_sw_q.push_id;

    thread_fifo q_to_rt_fifo_i (.clk(clk), .rst_n(rst_n), .q(q_to_rt.fifo));

    core_allocator #(.NUM_CORES(NUM_RT)) rt_alloc_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_release (rt_grant | task_done_rt),
        .dispatch     (job_dispatch_rt),
        .q            (q_to_rt.consumer)
    );

    // Saved context comes from the granted RT core
    context_store context_store_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .save     (q_to_ic.push),
        .save_id  (q_to_ic.push_id),
        .save_pc  (pc_in_rt[rt_grant_idx]),
        .save_sp  (stack_ptr_in_rt[rt_grant_idx]),
        .clear    (load_push),
        .clear_id (load_id),
        .rd_id    (q_to_rt.head),
        .rd_pc    (pc_out_rt),
        .rd_sp    (sp_out_rt)
    );

    // Load cycle 0 is the only loader push of entry 0
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            done_cnt <= '0;
        end else if (load_push && load_id == '0) begin
            done_cnt <= '0;
        end else begin
            done_cnt <= done_cnt + done_count_t'($countones(task_done_rt));
        end
    end

    assign patch_done = (done_cnt == done_count_t'(NUM_THREAD));

    assign thread_id_out_rt = q_to_rt.head;
    assign thread_id_out_ic = q_to_ic.head;

    assign q_en_rt2ic    = q_to_ic.push;
    assign core_id_rt2ic = rt_grant;
    assign q_en_ic2rt    = ic_sw_q.push;
    assign core_id_ic2rt = ic_grant;

endmodule

// File: tb_patch_dispatcher.sv
`timescale 1ns/1ps

module tb_patch_dispatcher import patch_pkg::*; ();

    localparam int CLK_HALF    = 20;
    localparam int PATCH_LIMIT = NUM_THREAD * 400;
    localparam int NUM_TESTS   = 3;
    localparam int WATCHDOG_NS = NUM_TESTS * PATCH_LIMIT * 2 * CLK_HALF;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       load_cp;
    word_t      pixel_id_cp;
    rt_mask_t   task_done_rt;
    rt_mask_t   context_switch_rt;
    thread_id_t thread_id_in_rt [NUM_RT];
    word_t      pc_in_rt [NUM_RT];
    word_t      stack_ptr_in_rt [NUM_RT];
    ic_mask_t   context_switch_ic;
    thread_id_t thread_id_in_ic [NUM_IC];
    logic       patch_done;
    rt_mask_t   job_dispatch_rt;
    thread_id_t thread_id_out_rt;
    word_t      pixel_id_rt;
    word_t      pc_out_rt;
    word_t      sp_out_rt;
    ic_mask_t   job_dispatch_ic;
    thread_id_t thread_id_out_ic;
    logic       q_en_rt2ic;
    rt_mask_t   core_id_rt2ic;
    logic       q_en_ic2rt;
    ic_mask_t   core_id_ic2rt;

    // Core model states are 0 free, 1 running and 2 waiting for the switch grant
    int         rt_state [NUM_RT];
    int         rt_timer [NUM_RT];
    thread_id_t rt_thr   [NUM_RT];
    word_t      rt_pc    [NUM_RT];
    word_t      rt_sp    [NUM_RT];
    int         ic_state [NUM_IC];
    int         ic_timer [NUM_IC];
    thread_id_t ic_thr   [NUM_IC];
    int         ic_hold;
    logic       rst_release;

    // Reference model
    thread_id_t q_rt [$];
    thread_id_t q_ic [$];
    word_t      pix_tbl  [NUM_THREAD];
    word_t      pc_tbl   [NUM_THREAD];
    word_t      sp_tbl   [NUM_THREAD];
    bit         finished [NUM_THREAD];
    int         done_cnt;
    int         load_k;
    int         errors;
    int         multi_req;
    int         backpressure;

    patch_dispatcher patch_dispatcher_i (.*);

    always #(CLK_HALF) clk = ~clk;

    task automatic check_tid(input string name, input thread_id_t got, input thread_id_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rt_mask(input string name, input rt_mask_t got, input rt_mask_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_ic_mask(input string name, input ic_mask_t got, input ic_mask_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Cores hold a thread for a random time, then finish or switch out
    task automatic drive_cores();
        task_done_rt      = '0;
        context_switch_rt = '0;
        context_switch_ic = '0;
        for (int i = 0; i < NUM_RT; i++) begin
            if (rt_state[i] == 1) begin
                if (rt_timer[i] > 0) begin
                    rt_timer[i]--;
                end else if ($urandom_range(2, 0) == 0) begin
                    task_done_rt[i] = 1'b1;
                end else begin
                    rt_pc[i]             = $urandom();
                    rt_sp[i]             = $urandom();
                    context_switch_rt[i] = 1'b1;
                    rt_state[i]          = 2;
                end
            end
            thread_id_in_rt[i] = rt_thr[i];
            pc_in_rt[i]        = rt_pc[i];
            stack_ptr_in_rt[i] = rt_sp[i];
        end
        for (int i = 0; i < NUM_IC; i++) begin
            if (ic_state[i] == 1) begin
                if (ic_timer[i] > 0) begin
                    ic_timer[i]--;
                end else begin
                    context_switch_ic[i] = 1'b1;
                    ic_state[i]          = 2;
                end
            end
            thread_id_in_ic[i] = ic_thr[i];
        end
    endtask

    // One clock that drives on the falling edge, checks, then updates the model
    task automatic step_cycle(input logic ld, input word_t pix);
        rt_mask_t   exp_rt_grant;
        rt_mask_t   exp_rt_disp;
        ic_mask_t   exp_ic_grant;
        ic_mask_t   exp_ic_disp;
        thread_id_t t;
        int         n_wait;
        @(negedge clk);
        rst_n       = rst_release;
        load_cp     = ld;
        pixel_id_cp = pix;
        drive_cores();
        #1;
        if (load_k < 0 && ld) begin
            load_k = 0;
        end
        exp_rt_grant = '0;
        exp_rt_disp  = '0;
        exp_ic_grant = '0;
        exp_ic_disp  = '0;
        n_wait       = 0;
        // Walk downwards so the lowest index is the one left standing
        for (int i = NUM_RT - 1; i >= 0; i--) begin
            if (rt_state[i] == 2) begin
                exp_rt_grant = rt_mask_t'(1 << i);
                n_wait++;
            end
            if (rt_state[i] == 0 && q_rt.size() > 0) begin
                exp_rt_disp = rt_mask_t'(1 << i);
            end
        end
        for (int i = NUM_IC - 1; i >= 0; i--) begin
            if (ic_state[i] == 2 && load_k < 0) begin
                exp_ic_grant = ic_mask_t'(1 << i);
            end
            if (ic_state[i] == 0 && q_ic.size() > 0) begin
                exp_ic_disp = ic_mask_t'(1 << i);
            end
        end
        if (n_wait > 1) begin
            multi_req++;
        end
        if (q_ic.size() > 0 && exp_ic_disp == '0) begin
            backpressure++;
        end

        check_rt_mask("core_id_rt2ic", core_id_rt2ic, exp_rt_grant);
        check_bit("q_en_rt2ic", q_en_rt2ic, |exp_rt_grant);
        check_ic_mask("core_id_ic2rt", core_id_ic2rt, exp_ic_grant);
        check_bit("q_en_ic2rt", q_en_ic2rt, |exp_ic_grant);
        check_rt_mask("job_dispatch_rt", job_dispatch_rt, exp_rt_disp);
        check_ic_mask("job_dispatch_ic", job_dispatch_ic, exp_ic_disp);
        check_bit("patch_done", patch_done, done_cnt == NUM_THREAD);

        if (exp_rt_disp != '0) begin
            t = q_rt.pop_front();
            check_tid("thread_id_out_rt", thread_id_out_rt, t);
            check_word("pixel_id_rt", pixel_id_rt, pix_tbl[t]);
            check_word("pc_out_rt", pc_out_rt, pc_tbl[t]);
            check_word("sp_out_rt", sp_out_rt, sp_tbl[t]);
            for (int i = 0; i < NUM_RT; i++) begin
                if (exp_rt_disp[i]) begin
                    rt_state[i] = 1;
                    rt_thr[i]   = thread_id_out_rt;
                    rt_timer[i] = $urandom_range(6, 0);
                end
            end
        end
        if (exp_ic_disp != '0) begin
            t = q_ic.pop_front();
            check_tid("thread_id_out_ic", thread_id_out_ic, t);
            for (int i = 0; i < NUM_IC; i++) begin
                if (exp_ic_disp[i]) begin
                    ic_state[i] = 1;
                    ic_thr[i]   = thread_id_out_ic;
                    ic_timer[i] = $urandom_range(ic_hold, 0);
                end
            end
        end

        for (int i = 0; i < NUM_RT; i++) begin
            if (exp_rt_grant[i]) begin
                q_ic.push_back(rt_thr[i]);
                pc_tbl[rt_thr[i]] = rt_pc[i];
                sp_tbl[rt_thr[i]] = rt_sp[i];
                rt_state[i]       = 0;
            end
            if (task_done_rt[i]) begin
                if (finished[rt_thr[i]]) begin
                    errors++;
                    $display("Thread %0d was reported done twice at %0t", rt_thr[i], $time);
                end
                finished[rt_thr[i]] = 1'b1;
                done_cnt++;
                rt_state[i] = 0;
            end
        end
        for (int i = 0; i < NUM_IC; i++) begin
            if (exp_ic_grant[i]) begin
                q_rt.push_back(ic_thr[i]);
                ic_state[i] = 0;
            end
        end

        if (load_k >= 0) begin
            if (load_k == 0) begin
                done_cnt = 0;
                for (int k = 0; k < NUM_THREAD; k++) begin
                    finished[k] = 1'b0;
                end
            end
            pix_tbl[load_k] = pixel_id_cp;
            pc_tbl[load_k]  = '0;
            sp_tbl[load_k]  = '0;
            q_rt.push_back(thread_id_t'(load_k));
            load_k = (load_k == NUM_THREAD - 1) ? -1 : load_k + 1;
        end
    endtask

    task automatic run_patch();
        int cycles;
        for (int k = 0; k < NUM_THREAD; k++) begin
            step_cycle(k == 0, $urandom());
        end
        cycles = 0;
        while (!patch_done && cycles < PATCH_LIMIT) begin
            step_cycle(1'b0, '0);
            cycles++;
        end
        if (!patch_done) begin
            errors++;
            $display("patch_done did not rise within %0d cycles", PATCH_LIMIT);
        end
        // patch_done has to stay up while idle
        repeat (8) step_cycle(1'b0, '0);
        for (int k = 0; k < NUM_THREAD; k++) begin
            if (!finished[k]) begin
                errors++;
                $display("Thread %0d was never reported done", k);
            end
        end
        if (q_rt.size() != 0 || q_ic.size() != 0) begin
            errors++;
            $display("Threads were still queued in the model after patch_done");
        end
    endtask

    task automatic report_test(input string name, input int fails);
        $display("Test %-28s %s, %0d errors", name, (fails == 0) ? "ok" : "failed", fails);
    endtask

    initial begin : test_seq
        int mark;
        int seen;
        rst_n             = 1'b0;
        rst_release       = 1'b0;
        load_cp           = 1'b0;
        pixel_id_cp       = '0;
        task_done_rt      = '0;
        context_switch_rt = '0;
        context_switch_ic = '0;
        for (int i = 0; i < NUM_RT; i++) begin
            rt_state[i]        = 0;
            rt_timer[i]        = 0;
            rt_thr[i]          = '0;
            rt_pc[i]           = '0;
            rt_sp[i]           = '0;
            thread_id_in_rt[i] = '0;
            pc_in_rt[i]        = '0;
            stack_ptr_in_rt[i] = '0;
        end
        for (int i = 0; i < NUM_IC; i++) begin
            ic_state[i]        = 0;
            ic_timer[i]        = 0;
            ic_thr[i]          = '0;
            thread_id_in_ic[i] = '0;
        end
        done_cnt     = 0;
        load_k       = -1;
        errors       = 0;
        multi_req    = 0;
        backpressure = 0;
        ic_hold      = 6;
        void'($urandom(32'h8de8e6f6));

        // Reset stays low over the first two rising edges
        mark = errors;
        step_cycle(1'b0, '0);
        rst_release = 1'b1;
        repeat (7) step_cycle(1'b0, '0);
        report_test("reset state", errors - mark);

        // Short IC holds and many colliding RT switches
        mark = errors;
        seen = multi_req;
        run_patch();
        if (multi_req == seen) begin
            errors++;
            $display("No cycle had two RT cores switching at once");
        end
        report_test("first patch, short IC holds", errors - mark);

        // Long IC holds fill every IC core
        mark    = errors;
        seen    = backpressure;
        ic_hold = 80;
        run_patch();
        if (backpressure == seen) begin
            errors++;
            $display("The IC queue never had to wait for a free core");
        end
        report_test("second patch, IC back-pressure", errors - mark);

        $display("Tests run: %0d, errors: %0d", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns and the run did not finish", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: patch_sched.f
patch_pkg.sv
thread_q_if.sv
thread_fifo.sv
switch_collector.sv
core_allocator.sv
pixel_loader.sv
context_store.sv
patch_dispatcher.sv
tb_patch_dispatcher.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f patch_sched.f --top-module tb_patch_dispatcher -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qx "STATUS: PASS" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
